//--- Bender.yml
package:
  name: lsu_path

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsuPkg.sv
      - logic/lsQueue.sv
      - logic/memPort.sv
      - logic/memCtrl.sv
      - logic/lsuTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/clkGen.sv
      - tests/lsuTop_sva.sv
      - tests/lsuTop_tb.sv

//--- logic/lsQueue.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsQueue import lsuPkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  reqValid,
    output logic  reqReady,
    input  lsReqT req,

    output logic  issueValid,
    input  logic  issueReady,
    output lsReqT issue
);

    localparam int Depth = `LSU_QUEUE_DEPTH;
    localparam int PtrW = $clog2(Depth);

    lsReqT entries [Depth];

    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0]   count;
    logic            full;
    logic            doPush;
    logic            doPop;

    assign full = (count == (PtrW + 1)'(Depth));

    // a full queue still takes a push when the head leaves in the same cycle.
    assign reqReady = !full || issueReady;
    assign issueValid = (count != '0);

    assign doPush = reqValid && reqReady;
    assign doPop = issueValid && issueReady;

    // head entry drives the issue side directly.
    assign issue = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= req;
        end
    end

endmodule

//--- logic/lsuPkg.sv
`include "lsu_cfg.svh"

package lsuPkg;

    // access size of one request.
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accLenE;

    typedef struct packed {
        logic                   isStore;
        accLenE                 len;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
        logic [`LSU_TAG_W-1:0]  tag;
    } lsReqT;

    // what the memory controller sees, the tag stays in the port.
    typedef struct packed {
        logic                   isStore;
        accLenE                 len;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
    } memReqT;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0] rdata;
        logic [`LSU_TAG_W-1:0]  tag;
    } lsRespT;

endpackage

//--- logic/lsuTop.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsuTop import lsuPkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   reqValid,
    output logic   reqReady,
    input  lsReqT  req,

    output logic   respValid,
    output lsRespT resp
);

    logic                   issueValid;
    logic                   issueReady;
    lsReqT                  issue;
    logic                   memValid;
    memReqT                 memReq;
    logic                   memBusy;
    logic                   memDone;
    logic [`LSU_DATA_W-1:0] memRdata;

    lsQueue queue (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .issueValid(issueValid), .issueReady(issueReady), .issue(issue)
    );

    memPort port (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueReady(issueReady), .issue(issue),
        .memValid(memValid), .memReq(memReq), .memBusy(memBusy),
        .memDone(memDone), .memRdata(memRdata),
        .respValid(respValid), .resp(resp)
    );

    memCtrl ctrl (
        .clk(clk), .rst(rst),
        .memValid(memValid), .memReq(memReq), .memBusy(memBusy),
        .memDone(memDone), .memRdata(memRdata)
    );

endmodule

//--- logic/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// widths of the core-side load/store interface.
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_TAG_W 4

// queue entries, kept a power of two so the pointers wrap for free.
`define LSU_QUEUE_DEPTH 4

// byte RAM size, addresses wrap modulo this size.
`define LSU_MEM_BYTES 1024
`endif

//--- logic/memCtrl.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module memCtrl import lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   memValid,
    input  memReqT                 memReq,
    output logic                   memBusy,

    output logic                   memDone,
    output logic [`LSU_DATA_W-1:0] memRdata
);

    localparam int AddrW = $clog2(`LSU_MEM_BYTES);

    typedef enum logic [1:0] {
        stIdle,
        stXfer,
        stFin,
        stDone
    } ctrlStateE;

    logic [7:0] ram [`LSU_MEM_BYTES];

    ctrlStateE              state;
    logic                   accept;
    logic                   isStore;
    logic [AddrW-1:0]       curAddr;
    logic [2:0]             nBytes;
    logic [2:0]             byteCnt;
    logic [`LSU_DATA_W-1:0] shiftReg;
    logic [7:0]             rdByte;
    logic [5:0]             shAmt;

    function automatic logic [2:0] byteCount(accLenE len);
        case (len)
            lenByte: return 3'd1;
            lenHalf: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    assign accept = memValid && (state == stIdle);
    assign memBusy = (state != stIdle);
    assign memDone = (state == stDone);

    assign rdByte = ram[curAddr];

    // loaded bytes end up in the top lanes, this brings them down to lane 0.
    assign shAmt = {3'd4 - nBytes, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            byteCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (memValid) begin
                        state   <= stXfer;
                        byteCnt <= '0;
                    end
                end
                stXfer: begin
                    byteCnt <= byteCnt + 1'b1;
                    if (byteCnt == nBytes - 3'd1) begin
                        state <= stFin;
                    end
                end
                stFin: begin
                    state <= stDone;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // one shift register serves both directions, store bytes leave at the
    // bottom while load bytes enter at the top.
    always_ff @(posedge clk) begin
        if (accept) begin
            isStore  <= memReq.isStore;
            curAddr  <= memReq.addr[AddrW-1:0];
            nBytes   <= byteCount(memReq.len);
            shiftReg <= memReq.wdata;
        end else if (state == stXfer) begin
            shiftReg <= {rdByte, shiftReg[`LSU_DATA_W-1:8]};
            curAddr  <= curAddr + 1'b1;
        end
        if (state == stFin) begin
            memRdata <= isStore ? '0 : (shiftReg >> shAmt);
        end
    end

    always_ff @(posedge clk) begin
        if ((state == stXfer) && isStore) begin
            ram[curAddr] <= shiftReg[7:0];
        end
    end

endmodule

//--- logic/memPort.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module memPort import lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   issueValid,
    output logic                   issueReady,
    input  lsReqT                  issue,

    output logic                   memValid,
    output memReqT                 memReq,
    input  logic                   memBusy,
    input  logic                   memDone,
    input  logic [`LSU_DATA_W-1:0] memRdata,

    output logic                   respValid,
    output lsRespT                 resp
);

    lsReqT held;
    logic  occupied;
    logic  issued;

    assign issueReady = !occupied;

    assign memReq = '{isStore: held.isStore, len: held.len,
                      addr: held.addr, wdata: held.wdata};

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            issued    <= 1'b0;
            memValid  <= 1'b0;
            respValid <= 1'b0;
        end else begin
            respValid <= memDone;
            if (memDone) begin
                occupied <= 1'b0;
                issued   <= 1'b0;
            end
            // the request goes out once, and drops as soon as it is taken.
            if (memValid && !memBusy) begin
                memValid <= 1'b0;
            end else if (occupied && !issued && !memBusy) begin
                memValid <= 1'b1;
                issued   <= 1'b1;
            end
            if (issueValid && issueReady) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid && issueReady) begin
            held <= issue;
        end
        if (memDone) begin
            resp <= '{rdata: memRdata, tag: held.tag};
        end
    end

endmodule

//--- project.f
+incdir+logic
logic/lsuPkg.sv
logic/lsQueue.sv
logic/memPort.sv
logic/memCtrl.sv
logic/lsuTop.sv
tests/clkGen.sv
tests/lsuTop_sva.sv
tests/lsuTop_tb.sv

//--- tests/clkGen.sv
`timescale 1ns/1ns

module clkGen (
    output logic clk,
    output logic rst
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/lsuTop_sva.sv
`timescale 1ns/1ns

module lsuTop_sva (
    input logic clk,
    input logic rst,
    input logic memValid,
    input logic memBusy,
    input logic memDone,
    input logic respValid,
    input logic issueValid,
    input logic issueReady
);

    int failCnt = 0;

    assert property (@(posedge clk) disable iff (rst) !(memValid && memBusy))
        else begin
            failCnt++;
            $error("memValid high while the controller is busy");
        end

    assert property (@(posedge clk) disable iff (rst) respValid |=> !respValid)
        else begin
            failCnt++;
            $error("respValid high on two cycles in a row");
        end

    // the slot closes on acceptance and opens again only with the response.
    assert property (@(posedge clk) disable iff (rst)
                     (issueValid && issueReady) |=> !issueReady)
        else begin
            failCnt++;
            $error("issueReady still high after a request was taken");
        end

    assert property (@(posedge clk) disable iff (rst) $rose(issueReady) |-> respValid)
        else begin
            failCnt++;
            $error("issueReady rose while a request was still held");
        end

    // a word is the slowest case with memDone six cycles after memValid.
    assert property (@(posedge clk) disable iff (rst) $rose(memValid) |-> ##[1:6] memDone)
        else begin
            failCnt++;
            $error("no memDone within 6 cycles of memValid");
        end

endmodule

bind memPort lsuTop_sva sva (
    .clk(clk), .rst(rst), .memValid(memValid), .memBusy(memBusy), .memDone(memDone),
    .respValid(respValid), .issueValid(issueValid), .issueReady(issueReady)
);

//--- tests/lsuTop_tb.sv
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsuTop_tb import lsuPkg::*; ();

    localparam int MaxWait = 400;

    logic   clk;
    logic   rst;
    logic   reqValid;
    logic   reqReady;
    lsReqT  req;
    logic   respValid;
    lsRespT resp;

    logic [7:0]            model [`LSU_MEM_BYTES];
    bit                    written [`LSU_MEM_BYTES];
    lsRespT                expQ [$];
    int                    errors;
    int                    checks;
    int                    testErrStart;
    bit                    hung;
    bit                    sawFull;
    logic [`LSU_TAG_W-1:0] nextTag;

    clkGen clock (.clk(clk), .rst(rst));

    lsuTop uut (
        .clk(clk), .rst(rst), .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .respValid(respValid), .resp(resp)
    );

    function automatic int sizeBytes(accLenE len);
        return (len == lenByte) ? 1 : ((len == lenHalf) ? 2 : 4);
    endfunction

    // little-endian merge of the model bytes with zeros above the access size.
    function automatic logic [`LSU_DATA_W-1:0] loadModel(logic [`LSU_ADDR_W-1:0] addr,
                                                         accLenE len);
        logic [`LSU_DATA_W-1:0] data;
        data = '0;
        for (int k = 0; k < sizeBytes(len); k++) begin
            data[8*k +: 8] = model[(addr + k) % `LSU_MEM_BYTES];
        end
        return data;
    endfunction

    task automatic checkVal(string name, logic [`LSU_DATA_W-1:0] got,
                            logic [`LSU_DATA_W-1:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERR %0t ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    task automatic timedOut(string what);
        errors++;
        hung = 1'b1;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    // offer one request from a falling edge and return on the falling edge after it is taken.
    task automatic sendReq(bit isStore, accLenE len, logic [`LSU_ADDR_W-1:0] addr,
                           logic [`LSU_DATA_W-1:0] wdata);
        lsRespT want;
        int     waitCnt;
        bit     taken;
        req = '{isStore: isStore, len: len, addr: addr, wdata: wdata, tag: nextTag};
        reqValid = 1'b1;
        want.tag = nextTag;
        want.rdata = isStore ? '0 : loadModel(addr, len);
        taken = 1'b0;
        waitCnt = 0;
        while (!taken && !hung) begin
            sawFull |= !reqReady;
            taken = reqReady;
            @(negedge clk);
            waitCnt++;
            if (!taken && waitCnt > MaxWait) begin
                timedOut($sformatf("request with tag %0d never accepted", nextTag));
            end
        end
        reqValid = 1'b0;
        if (taken) begin
            if (isStore) begin
                for (int k = 0; k < sizeBytes(len); k++) begin
                    model[(addr + k) % `LSU_MEM_BYTES] = wdata[8*k +: 8];
                    written[(addr + k) % `LSU_MEM_BYTES] = 1'b1;
                end
            end
            expQ.push_back(want);
        end
        nextTag++;
    endtask

    task automatic waitDrain();
        int waitCnt;
        waitCnt = 0;
        while (expQ.size() != 0 && !hung) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > MaxWait) begin
                timedOut($sformatf("%0d responses still missing", expQ.size()));
            end
        end
    endtask

    // responses are compared in order against the oldest expected one.
    always @(negedge clk) begin
        lsRespT want;
        if (!rst && respValid) begin
            checks++;
            assert (expQ.size() != 0) else begin
                errors++;
                $display("response with tag %0d arrived with nothing pending", resp.tag);
            end
            if (expQ.size() != 0) begin
                want = expQ.pop_front();
                checkVal("resp.tag", resp.tag, want.tag);
                checkVal("resp.rdata", resp.rdata, want.rdata);
            end
        end
    end

    task automatic reportTest(int num, string name);
        $display("test %0d %s: %0d errors", num, name, errors - testErrStart);
        testErrStart = errors;
    endtask

    task automatic checkReset();
        int waitCnt;
        waitCnt = 0;
        do begin
            @(negedge clk);
            checkVal("respValid", respValid, 1'b0);
            checkVal("reqReady", reqReady, 1'b1);
            waitCnt++;
            if (waitCnt > MaxWait) begin
                timedOut("reset never released");
            end
        end while (rst && !hung);
        @(negedge clk);
        checkVal("respValid", respValid, 1'b0);
        checkVal("reqReady", reqReady, 1'b1);
    endtask

    task automatic wordStoreLoad();
        sendReq(1'b1, lenWord, 32'h20, 32'hdeadbeef);
        sendReq(1'b0, lenWord, 32'h20, '0);
        waitDrain();
    endtask

    task automatic subwordMerge();
        sendReq(1'b1, lenWord, 32'h40, 32'h55667788);
        sendReq(1'b1, lenByte, 32'h40, 32'h000000a5);
        sendReq(1'b1, lenByte, 32'h41, 32'hffffff3c);
        sendReq(1'b1, lenHalf, 32'h42, 32'h1234c7e9);
        sendReq(1'b0, lenWord, 32'h40, '0);
        sendReq(1'b0, lenByte, 32'h41, '0);
        sendReq(1'b0, lenHalf, 32'h42, '0);
        sendReq(1'b0, lenByte, 32'h43, '0);
        waitDrain();
    endtask

    task automatic burstTraffic();
        sawFull = 1'b0;
        for (int i = 0; i < 8; i++) begin
            sendReq(i < 4, lenWord, 32'h80 + 4 * (i % 4), 32'ha0b0c000 + i);
        end
        checks++;
        assert (sawFull) else begin
            errors++;
            $display("reqReady never fell during the burst");
        end
        waitDrain();
    endtask

    task automatic randomTraffic();
        logic [`LSU_ADDR_W-1:0] addr;
        accLenE                 len;
        bit                     allWritten;
        for (int i = 0; i < 200; i++) begin
            addr = 32'h200 + $urandom_range(0, 63);
            len = accLenE'($urandom_range(0, 2));
            allWritten = 1'b1;
            for (int k = 0; k < sizeBytes(len); k++) begin
                allWritten &= written[(addr + k) % `LSU_MEM_BYTES];
            end
            // a load over unwritten bytes turns into a store.
            sendReq($urandom_range(0, 1) || !allWritten, len, addr, $urandom);
        end
        waitDrain();
    endtask

    task automatic addressWrap();
        sendReq(1'b1, lenWord, `LSU_MEM_BYTES - 2, 32'hcafe0123);
        for (int k = 0; k < 4; k++) begin
            sendReq(1'b0, lenByte, (`LSU_MEM_BYTES - 2 + k) % `LSU_MEM_BYTES, '0);
        end
        sendReq(1'b0, lenWord, `LSU_MEM_BYTES - 2, '0);
        waitDrain();
    endtask

    initial begin
        void'($urandom(32'h3ab6ca6e));
        reqValid = 1'b0;
        req = '0;
        errors = 0;
        checks = 0;
        testErrStart = 0;
        hung = 1'b0;
        sawFull = 1'b0;
        nextTag = '0;
        checkReset();
        reportTest(1, "reset state");
        wordStoreLoad();
        reportTest(2, "word store and load");
        subwordMerge();
        reportTest(3, "byte and half merge");
        burstTraffic();
        reportTest(4, "burst with back-pressure");
        randomTraffic();
        reportTest(5, "random traffic");
        addressWrap();
        reportTest(6, "address wrap");
        errors += uut.port.sva.failCnt;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !hung) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
